/* snd_pkg.sv */
package snd_pkg;

  localparam int BYTE_W   = 8;
  localparam int MIX_W    = 12;
  localparam int SAMPLE_W = 16;

  // Bus byte, also one covox channel value
  typedef logic [BYTE_W-1:0]   byte_t;

  // Low half of the I/O address, the high byte is not decoded
  typedef logic [7:0]          io_addr_t;

  typedef logic [MIX_W-1:0]    mix_t;
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Beeper and tape out
  localparam io_addr_t PORT_FE = 8'hFE;

  // Soundrive channels
  localparam io_addr_t PORT_COVOX_A   = 8'h0F;
  localparam io_addr_t PORT_COVOX_B   = 8'h1F;
  localparam io_addr_t PORT_COVOX_C   = 8'h4F;
  localparam io_addr_t PORT_COVOX_D   = 8'h5F;
  // All four channels in one write
  localparam io_addr_t PORT_COVOX_ALL = 8'hFB;

  localparam int BEEP_BIT = 4;
  localparam int TAPE_BIT = 3;

  // Mix weights
  localparam int COVOX_SHIFT = 2;
  localparam int BEEP_WEIGHT = 256;

  // Above the knee the excess is halved
  localparam int KNEE      = 2048;
  localparam int OUT_SHIFT = 4;

endpackage

/* sound_regs.sv */
`timescale 1ns/10ps

module sound_regs (
  input  logic              fclk,
  input  logic              arst_n,
  input  logic              io_wr,
  input  logic              dos,
  input  snd_pkg::io_addr_t io_addr,
  input  snd_pkg::byte_t    io_data,
  output logic              beep,
  output logic              tape_out,
  output snd_pkg::byte_t    covox_a,
  output snd_pkg::byte_t    covox_b,
  output snd_pkg::byte_t    covox_c,
  output snd_pkg::byte_t    covox_d
);

  import snd_pkg::*;

  localparam int NUM_CH = 4;

  // Channel order is A, B, C, D
  localparam io_addr_t CH_PORT [NUM_CH] = '{
    PORT_COVOX_A,
    PORT_COVOX_B,
    PORT_COVOX_C,
    PORT_COVOX_D
  };

  byte_t port_fe;
  byte_t chan [NUM_CH];

  logic fe_hit;
  logic covox_en;
  logic all_hit;

  // Port FE decode
  assign fe_hit = io_wr && (io_addr == PORT_FE);

  // Soundrive ports vanish while DOS is paged in
  assign covox_en = io_wr && !dos;
  assign all_hit  = covox_en && (io_addr == PORT_COVOX_ALL);

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      port_fe <= '0;
    end else if (fe_hit) begin
      port_fe <= io_data;
    end
  end

  assign beep     = port_fe[BEEP_BIT];
  assign tape_out = port_fe[TAPE_BIT];

  // One register per covox channel
  for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
    logic hit;

    assign hit = all_hit || (covox_en && (io_addr == CH_PORT[i]));

    always_ff @(posedge fclk or negedge arst_n) begin
      if (!arst_n) begin
        chan[i] <= '0;
      end else if (hit) begin
        chan[i] <= io_data;
      end
    end
  end

  // Left pair
  assign covox_a = chan[0];
  assign covox_b = chan[1];
  // Right pair
  assign covox_c = chan[2];
  assign covox_d = chan[3];

  // A strobe must come with a clean address and DOS state
  a_wr_known: assert property (
    @(posedge fclk) disable iff (!arst_n)
    io_wr |-> !$isunknown(io_addr) && !$isunknown(dos)
  ) else $error("sound_regs: write strobe with unknown address or dos");

endmodule

/* audio_mixer.sv */
`timescale 1ns/10ps

module audio_mixer #(
  parameter int SAMPLE_DIV = 64
) (
  input  logic             fclk,
  input  logic             arst_n,
  input  logic             beep,
  input  snd_pkg::byte_t   covox_a,
  input  snd_pkg::byte_t   covox_b,
  input  snd_pkg::byte_t   covox_c,
  input  snd_pkg::byte_t   covox_d,
  output logic             mix_valid,
  output snd_pkg::sample_t mix_l,
  output snd_pkg::sample_t mix_r
);

  import snd_pkg::*;

  localparam int CNT_W = $clog2(SAMPLE_DIV);
  // One spare bit to catch overflow of the raw sums
  localparam int RAW_W = MIX_W + 1;

  if (SAMPLE_DIV < 4) begin : g_div_check
    $error("audio_mixer: SAMPLE_DIV must be at least 4");
  end

  logic [CNT_W-1:0] div_cnt;
  logic             tick;

  logic [RAW_W-1:0] beep_term;
  logic [RAW_W-1:0] raw_l;
  logic [RAW_W-1:0] raw_r;

  logic             s1_valid;
  mix_t             sum_l;
  mix_t             sum_r;

  // Soft knee, then scale the 12-bit level up to the sample width
  function automatic sample_t compress(input mix_t m);
    mix_t c;
    if (m > mix_t'(KNEE)) begin
      c = mix_t'(KNEE) + ((m - mix_t'(KNEE)) >> 1);
    end else begin
      c = m;
    end
    return sample_t'(c) << OUT_SHIFT;
  endfunction

  // Sample rate divider
  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      tick <= (div_cnt == CNT_W'(SAMPLE_DIV - 1));
      if (div_cnt == CNT_W'(SAMPLE_DIV - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  assign beep_term = beep ? RAW_W'(BEEP_WEIGHT) : '0;

  assign raw_l = (RAW_W'(covox_a) << COVOX_SHIFT)
               + (RAW_W'(covox_b) << COVOX_SHIFT)
               + beep_term;
  assign raw_r = (RAW_W'(covox_c) << COVOX_SHIFT)
               + (RAW_W'(covox_d) << COVOX_SHIFT)
               + beep_term;

  // Pipeline valid bits
  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      mix_valid <= 1'b0;
    end else begin
      s1_valid  <= tick;
      mix_valid <= s1_valid;
    end
  end

  // Stage 1, raw sums
  always_ff @(posedge fclk) begin
    if (tick) begin
      sum_l <= raw_l[MIX_W-1:0];
      sum_r <= raw_r[MIX_W-1:0];
    end
  end

  // Stage 2, compressed output
  always_ff @(posedge fclk) begin
    if (s1_valid) begin
      mix_l <= compress(sum_l);
      mix_r <= compress(sum_r);
    end
  end

  a_sum_range: assert property (
    @(posedge fclk) disable iff (!arst_n)
    tick |-> !raw_l[MIX_W] && !raw_r[MIX_W]
  ) else $error("audio_mixer: mix sum outside 12-bit range");

  // Pushes are at least a sample period apart
  a_push_single: assert property (
    @(posedge fclk) disable iff (!arst_n)
    mix_valid |=> !mix_valid
  ) else $error("audio_mixer: mix_valid high on back-to-back cycles");

endmodule

/* sample_buffer.sv */
`timescale 1ns/10ps

module sample_buffer #(
  parameter int BUF_DEPTH = 2
) (
  input  logic             fclk,
  input  logic             arst_n,
  input  logic             push,
  input  snd_pkg::sample_t push_l,
  input  snd_pkg::sample_t push_r,
  output logic             out_valid,
  input  logic             out_ready,
  output snd_pkg::sample_t sound_l,
  output snd_pkg::sample_t sound_r,
  output logic             overrun
);

  import snd_pkg::*;

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  sample_t mem_l [BUF_DEPTH];
  sample_t mem_r [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic wr_en;
  logic rd_en;

  assign full  = (count == CNT_W'(BUF_DEPTH));
  // A push into a full buffer is lost
  assign wr_en = push && !full;
  assign rd_en = out_valid && out_ready;

  assign out_valid = (count != '0);
  assign sound_l   = mem_l[rd_ptr];
  assign sound_r   = mem_r[rd_ptr];

  always_ff @(posedge fclk) begin
    if (wr_en) begin
      mem_l[wr_ptr] <= push_l;
      mem_r[wr_ptr] <= push_r;
    end
  end

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
      // Sticky until reset
      if (push && full) begin
        overrun <= 1'b1;
      end
    end
  end

  a_hold_stable: assert property (
    @(posedge fclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(sound_l) && $stable(sound_r)
  ) else $error("sample_buffer: output changed while stalled");

endmodule

/* sound_top.sv */
`timescale 1ns/10ps

module sound_top #(
  parameter int SAMPLE_DIV = 64,
  parameter int BUF_DEPTH  = 2
) (
  input  logic              fclk,
  input  logic              arst_n,
  input  logic              io_wr,
  input  logic              dos,
  input  snd_pkg::io_addr_t io_addr,
  input  snd_pkg::byte_t    io_data,
  output logic              tape_out,
  output logic              out_valid,
  input  logic              out_ready,
  output snd_pkg::sample_t  sound_l,
  output snd_pkg::sample_t  sound_r,
  output logic              overrun
);

  import snd_pkg::*;

  logic    beep;
  byte_t   covox_a;
  byte_t   covox_b;
  byte_t   covox_c;
  byte_t   covox_d;

  logic    mix_valid;
  sample_t mix_l;
  sample_t mix_r;

  sound_regs regs_i (
    .fclk     (fclk),
    .arst_n   (arst_n),
    .io_wr    (io_wr),
    .dos      (dos),
    .io_addr  (io_addr),
    .io_data  (io_data),
    .beep     (beep),
    .tape_out (tape_out),
    .covox_a  (covox_a),
    .covox_b  (covox_b),
    .covox_c  (covox_c),
    .covox_d  (covox_d)
  );

  audio_mixer #(
    .SAMPLE_DIV (SAMPLE_DIV)
  ) mixer_i (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .beep      (beep),
    .covox_a   (covox_a),
    .covox_b   (covox_b),
    .covox_c   (covox_c),
    .covox_d   (covox_d),
    .mix_valid (mix_valid),
    .mix_l     (mix_l),
    .mix_r     (mix_r)
  );

  // Absorbs stalls from the downstream consumer
  sample_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) buffer_i (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .push      (mix_valid),
    .push_l    (mix_l),
    .push_r    (mix_r),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .sound_l   (sound_l),
    .sound_r   (sound_r),
    .overrun   (overrun)
  );

endmodule

/* tb_sound.sv */
`timescale 1ns/10ps

module tb_sound;

  import snd_pkg::*;

  localparam int SAMPLE_DIV = 16;
  localparam int BUF_DEPTH  = 2;

  logic     fclk;
  logic     arst_n;
  logic     io_wr;
  logic     dos;
  io_addr_t io_addr;
  byte_t    io_data;
  logic     tape_out;
  logic     out_valid;
  logic     out_ready;
  sample_t  sound_l;
  sample_t  sound_r;
  logic     overrun;

  // Mirror of the sound registers
  byte_t    m_fe;
  byte_t    m_a;
  byte_t    m_b;
  byte_t    m_c;
  byte_t    m_d;

  logic        arst_q = 1'b0;
  logic [1:0]  since_wr;
  logic        settled;
  logic        first_pending;
  logic        stall_seen;
  logic        draining;
  logic        accept;
  int          acc_total;
  int          drain_cnt;
  logic [31:0] rng_state = 32'd8243;
  sample_t     exp_l;
  sample_t     exp_r;

  sound_top #(
    .SAMPLE_DIV (SAMPLE_DIV),
    .BUF_DEPTH  (BUF_DEPTH)
  ) dut_i (
    .fclk      (fclk),
    .arst_n    (arst_n),
    .io_wr     (io_wr),
    .dos       (dos),
    .io_addr   (io_addr),
    .io_data   (io_data),
    .tape_out  (tape_out),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .sound_l   (sound_l),
    .sound_r   (sound_r),
    .overrun   (overrun)
  );

  initial begin
    fclk = 1'b0;
    forever #4 fclk = ~fclk;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("Something failed");
    $fatal(1, "stopped on timeout");
  endtask

  // Weighted sum of two covox channels and the beeper
  function automatic int mix_level(input byte_t a, input byte_t b, input logic bp);
    return a * 4 + b * 4 + (bp ? 256 : 0);
  endfunction

  // Excess above 2048 is halved, then the level is scaled by 16
  function automatic sample_t out_sample(input int m);
    int c;
    if (m <= 2048) begin
      c = m;
    end else begin
      c = 2048 + (m - 2048) / 2;
    end
    return sample_t'(c * 16);
  endfunction

  function automatic byte_t next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[23:16];
  endfunction

  function automatic io_addr_t chan_port(input logic [1:0] sel);
    case (sel)
      2'd0:    return PORT_COVOX_A;
      2'd1:    return PORT_COVOX_B;
      2'd2:    return PORT_COVOX_C;
      default: return PORT_COVOX_D;
    endcase
  endfunction

  assign accept  = out_valid && out_ready;
  assign settled = (since_wr == 2'd2);

  always_comb begin
    exp_l = out_sample(mix_level(m_a, m_b, m_fe[BEEP_BIT]));
    exp_r = out_sample(mix_level(m_c, m_d, m_fe[BEEP_BIT]));
  end

  always_ff @(posedge fclk) begin
    arst_q <= arst_n;
  end

  // Reference model and sample bookkeeping
  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      m_fe          <= '0;
      m_a           <= '0;
      m_b           <= '0;
      m_c           <= '0;
      m_d           <= '0;
      since_wr      <= '0;
      first_pending <= 1'b1;
      stall_seen    <= 1'b0;
      acc_total     <= 0;
      drain_cnt     <= 0;
    end else begin
      if (io_wr) begin
        if (io_addr == 8'hFE) m_fe <= io_data;
        if (!dos) begin
          if (io_addr == 8'h0F || io_addr == 8'hFB) m_a <= io_data;
          if (io_addr == 8'h1F || io_addr == 8'hFB) m_b <= io_data;
          if (io_addr == 8'h4F || io_addr == 8'hFB) m_c <= io_data;
          if (io_addr == 8'h5F || io_addr == 8'hFB) m_d <= io_data;
        end
      end
      // Samples still in flight at a write are not compared
      if (io_wr) begin
        since_wr <= '0;
      end else if (accept && since_wr != 2'd2) begin
        since_wr <= since_wr + 1'b1;
      end
      if (accept) begin
        acc_total     <= acc_total + 1;
        first_pending <= 1'b0;
      end
      if (accept && draining) begin
        drain_cnt <= drain_cnt + 1;
      end
      if (!out_ready) begin
        stall_seen <= 1'b1;
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge fclk) (!arst_n || !arst_q) |-> !out_valid && !overrun && !tape_out
  ) else report_mismatch("outputs active during or right after reset");

  a_first_zero: assert property (
    @(posedge fclk) disable iff (!arst_n)
    accept && first_pending |-> sound_l == '0 && sound_r == '0
  ) else report_mismatch($sformatf("first sample %h/%h is not zero",
                         $sampled(sound_l), $sampled(sound_r)));

  a_tape: assert property (
    @(posedge fclk) disable iff (!arst_n)
    tape_out == m_fe[TAPE_BIT]
  ) else report_mismatch("tape_out differs from bit 3 of port FE");

  a_sample: assert property (
    @(posedge fclk) disable iff (!arst_n)
    accept && settled |-> sound_l == exp_l && sound_r == exp_r
  ) else report_mismatch($sformatf("sample %h/%h, expected %h/%h",
                         $sampled(sound_l), $sampled(sound_r),
                         $sampled(exp_l), $sampled(exp_r)));

  // Full scale with beeper lands above the knee
  a_knee: assert property (
    @(posedge fclk) disable iff (!arst_n)
    accept && settled && m_fe[BEEP_BIT] && m_a == 8'hFF && m_b == 8'hFF &&
    m_c == 8'hFF && m_d == 8'hFF |->
    sound_l == 16'((2048 + 124) * 16) && sound_r == 16'((2048 + 124) * 16)
  ) else report_mismatch("full scale sample not compressed at the knee");

  a_hold: assert property (
    @(posedge fclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(sound_l) && $stable(sound_r)
  ) else report_mismatch("output sample changed while stalled");

  a_no_overrun: assert property (
    @(posedge fclk) disable iff (!arst_n)
    !stall_seen |-> !overrun
  ) else report_mismatch("overrun set without a stall");

  a_overrun_sticky: assert property (
    @(posedge fclk) disable iff (!arst_n)
    overrun |=> overrun
  ) else report_mismatch("overrun cleared before reset");

  a_drain_count: assert property (
    @(posedge fclk) disable iff (!arst_n)
    draining && drain_cnt == BUF_DEPTH |-> !out_valid
  ) else report_mismatch("more samples drained than the buffer holds");

  // Called right after a rising edge
  task automatic io_write(input io_addr_t addr, input byte_t data, input logic dos_v);
    io_wr   <= 1'b1;
    io_addr <= addr;
    io_data <= data;
    dos     <= dos_v;
    @(posedge fclk);
    io_wr   <= 1'b0;
    dos     <= 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int target;
    int waited;
    target = acc_total + n;
    waited = 0;
    while (acc_total < target) begin
      @(posedge fclk);
      waited++;
      if (waited > n * 2 * SAMPLE_DIV + 20) report_timeout("accepted samples did not arrive");
    end
  endtask

  task automatic wait_settled();
    int waited;
    waited = 0;
    while (!settled) begin
      @(posedge fclk);
      waited++;
      if (waited > 4 * SAMPLE_DIV + 20) report_timeout("samples never settled after a write");
    end
  endtask

  initial begin
    int waited;
    logic [1:0] sel;
    arst_n    = 1'b0;
    io_wr     = 1'b0;
    dos       = 1'b0;
    io_addr   = '0;
    io_data   = '0;
    out_ready = 1'b1;
    draining  = 1'b0;
    repeat (4) @(posedge fclk);
    arst_n <= 1'b1;
    wait_samples(1);

    // Beeper and tape
    io_write(PORT_FE, 8'h18, 1'b0);
    wait_settled();
    wait_samples(2);
    io_write(PORT_FE, 8'h08, 1'b0);
    wait_settled();
    wait_samples(2);
    io_write(8'hFF, 8'h10, 1'b0);
    io_write(8'hFD, 8'h10, 1'b0);
    wait_settled();
    wait_samples(2);
    io_write(PORT_FE, 8'h10, 1'b0);
    wait_settled();
    wait_samples(2);

    for (int i = 0; i < 10; i++) begin
      sel = next_rand() % 4;
      io_write(chan_port(sel), next_rand(), 1'b0);
      wait_settled();
      wait_samples(2);
    end

    // All channels at once, then blocked by dos
    io_write(PORT_COVOX_ALL, next_rand(), 1'b0);
    wait_settled();
    wait_samples(2);
    io_write(PORT_COVOX_ALL, next_rand(), 1'b1);
    io_write(PORT_COVOX_A, next_rand(), 1'b1);
    io_write(PORT_COVOX_D, next_rand(), 1'b1);
    wait_settled();
    wait_samples(3);

    io_write(PORT_COVOX_ALL, 8'hFF, 1'b0);
    io_write(PORT_FE, 8'h10, 1'b0);
    wait_settled();
    wait_samples(3);

    // Stall the consumer until the buffer overflows
    out_ready <= 1'b0;
    @(posedge fclk);
    waited = 0;
    while (!out_valid) begin
      @(posedge fclk);
      waited++;
      if (waited > 2 * SAMPLE_DIV + 10) report_timeout("out_valid never rose during stall");
    end
    waited = 0;
    while (!overrun) begin
      @(posedge fclk);
      waited++;
      if (waited > 4 * SAMPLE_DIV + 10) report_timeout("overrun never set during stall");
    end
    out_ready <= 1'b1;
    draining  <= 1'b1;
    waited = 0;
    while (drain_cnt < BUF_DEPTH) begin
      @(posedge fclk);
      waited++;
      if (waited > 10) report_timeout("buffered samples did not drain");
    end
    draining <= 1'b0;
    wait_samples(3);

    $display("Everything OK");
    $finish;
  end

endmodule

/* sim.f */
snd_pkg.sv
sound_regs.sv
audio_mixer.sv
sample_buffer.sv
sound_top.sv
tb_sound.sv

/* Bender.yml */
package:
  name: sound_path

sources:
  - snd_pkg.sv
  - sound_regs.sv
  - audio_mixer.sv
  - sample_buffer.sv
  - sound_top.sv
  - target: simulation
    files:
      - tb_sound.sv
